//--- design/la_pkg.sv
package la_pkg;

  // capture buffer geometry
  localparam int DEPTH  = 256;
  localparam int ADDR_W = 8;

  // host flow control
  localparam int CREDIT_MAX = 4;
  localparam int CREDIT_W   = $clog2(CREDIT_MAX + 1);

  // key handling
  localparam int DEBOUNCE_CYCLES = 16;
  localparam int DEB_W           = $clog2(DEBOUNCE_CYCLES + 1);
  localparam int VIEW_STEP       = 16;

  // trigger mode codes, anything above MODE_ANY fires at once
  localparam logic [2:0] MODE_HIGH = 3'd0;
  localparam logic [2:0] MODE_LOW  = 3'd1;
  localparam logic [2:0] MODE_RISE = 3'd2;
  localparam logic [2:0] MODE_FALL = 3'd3;
  localparam logic [2:0] MODE_ANY  = 3'd4;

  // sample period per freq_sel, 2**sel cycles
  localparam int DIV_W = 16;
  localparam logic [DIV_W-1:0] DIV_TABLE [16] = '{
    16'd1,    16'd2,    16'd4,     16'd8,
    16'd16,   16'd32,   16'd64,    16'd128,
    16'd256,  16'd512,  16'd1024,  16'd2048,
    16'd4096, 16'd8192, 16'd16384, 16'd32768
  };

  typedef struct packed {
    logic [1:0] rsvd;
    logic [2:0] lanes;  // bit 5 is the watched lane
    logic [2:0] pad;
  } spi_view_t;

  // one sample byte, seen raw or as spi lanes
  typedef union packed {
    logic [7:0] raw;
    spi_view_t  spi;
  } la_sample_u;

  typedef struct packed {
    logic [2:0]        chn;     // bit of raw word under watch
    logic [2:0]        mode;
    logic [ADDR_W-1:0] pre_num;
  } trig_cfg_t;

  typedef struct packed {
    logic [ADDR_W-1:0] index;   // position in stream
    la_sample_u        sample;
  } rd_beat_t;

endpackage

//--- design/freq_div.sv
`timescale 1ns/10ps

module freq_div (
  input  logic       i_sys_clk,
  input  logic       i_reset,
  input  logic [3:0] i_freq_sel,
  output logic       o_clken
);
  import la_pkg::*;

  logic [DIV_W-1:0] cnt;
  logic [DIV_W-1:0] last;
  logic [3:0]       sel_q;  // rate of the running period

  assign last    = DIV_TABLE[sel_q] - 1'b1;
  assign o_clken = !i_reset && (cnt == last);  // quiet while in reset

  always_ff @(posedge i_sys_clk) begin
    if (i_reset) begin
      cnt   <= '0;
      sel_q <= i_freq_sel;
    end else if (o_clken) begin
      cnt   <= '0;
      sel_q <= i_freq_sel;  // new rate only picked up on wrap
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- design/key_filter.sv
`timescale 1ns/10ps

module key_filter (
  input  logic i_sys_clk,
  input  logic i_reset,
  input  logic i_key,         // active low
  output logic o_press_flag
);
  import la_pkg::*;

  logic [1:0]       key_sync;
  logic             key_low;
  logic [DEB_W-1:0] low_cnt;

  assign key_low = ~key_sync[1];

  always_ff @(posedge i_sys_clk) begin
    if (i_reset) begin
      key_sync     <= 2'b11;  // released
      low_cnt      <= '0;
      o_press_flag <= 1'b0;
    end else begin
      key_sync     <= {key_sync[0], i_key};
      o_press_flag <= 1'b0;
      if (!key_low) begin
        low_cnt <= '0;  // bounce or release restarts the count
      end else if (low_cnt != DEB_W'(DEBOUNCE_CYCLES)) begin
        low_cnt <= low_cnt + 1'b1;
        // one flag per press, counter then parks until release
        if (low_cnt == DEB_W'(DEBOUNCE_CYCLES - 1)) begin
          o_press_flag <= 1'b1;
        end
      end
    end
  end

endmodule

//--- design/sample_ctrl.sv
`timescale 1ns/10ps

module sample_ctrl (
  input  logic                      i_sys_clk,
  input  logic                      i_reset,
  input  logic                      i_clken,
  input  logic                      i_trigger_en,
  input  la_pkg::trig_cfg_t         i_cfg,
  input  la_pkg::la_sample_u        i_sample,
  output logic                      o_wr_en,
  output logic [la_pkg::ADDR_W-1:0] o_wr_addr,
  output la_pkg::la_sample_u        o_wr_data,
  output logic [la_pkg::ADDR_W-1:0] o_start_addr,
  output logic                      o_finished
);
  import la_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_PRE,
    S_WAIT,
    S_POST,
    S_DONE
  } state_t;

  state_t            state;
  trig_cfg_t         cfg_q;     // setup latched at arm
  la_sample_u        prev;      // last sampled word, for edges
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W:0]   cnt;       // pre count, then post count
  logic [ADDR_W:0]   cnt_inc;
  logic [ADDR_W:0]   post_len;
  logic              capturing;
  logic              cur_bit;
  logic              old_bit;
  logic              hit;

  assign cnt_inc   = cnt + 1'b1;
  assign post_len  = (ADDR_W+1)'(DEPTH) - {1'b0, cfg_q.pre_num};
  assign capturing = (state == S_PRE) || (state == S_WAIT) || (state == S_POST);

  assign cur_bit = i_sample.raw[cfg_q.chn];
  assign old_bit = prev.raw[cfg_q.chn];

  // trigger condition on current vs previous sample
  always_comb begin
    case (cfg_q.mode)
      MODE_HIGH: hit = cur_bit;
      MODE_LOW:  hit = ~cur_bit;
      MODE_RISE: hit = cur_bit & ~old_bit;
      MODE_FALL: hit = ~cur_bit & old_bit;
      MODE_ANY:  hit = cur_bit ^ old_bit;
      default:   hit = 1'b1;  // immediate
    endcase
  end

  always_ff @(posedge i_sys_clk) begin
    if (i_reset) begin
      state        <= S_IDLE;
      cfg_q        <= '0;
      prev         <= '0;
      wr_ptr       <= '0;
      cnt          <= '0;
      o_wr_en      <= 1'b0;
      o_start_addr <= '0;
      o_finished   <= 1'b0;
    end else begin
      o_wr_en <= i_clken & capturing;  // write lands one cycle after clken
      if (i_clken) begin
        prev <= i_sample;
      end

      if (i_trigger_en) begin
        cfg_q      <= i_cfg;
        wr_ptr     <= '0;
        cnt        <= '0;
        o_finished <= 1'b0;
        state      <= (i_cfg.pre_num == '0) ? S_WAIT : S_PRE;
      end else begin
        case (state)
          S_PRE: begin
            if (i_clken) begin
              wr_ptr <= wr_ptr + 1'b1;
              cnt    <= cnt_inc;
              if (cnt_inc >= {1'b0, cfg_q.pre_num}) begin
                state <= S_WAIT;
              end
            end
          end

          S_WAIT: begin
            if (i_clken) begin
              wr_ptr <= wr_ptr + 1'b1;  // ring keeps the newest pre samples
              if (hit) begin
                o_start_addr <= wr_ptr - cfg_q.pre_num;
                cnt          <= (ADDR_W+1)'(1);  // trigger sample counts as post
                state        <= (post_len == (ADDR_W+1)'(1)) ? S_DONE : S_POST;
              end
            end
          end

          S_POST: begin
            if (i_clken) begin
              wr_ptr <= wr_ptr + 1'b1;
              cnt    <= cnt_inc;
              if (cnt_inc == post_len) begin
                state <= S_DONE;
              end
            end
          end

          S_DONE: o_finished <= 1'b1;  // last write is in this cycle

          default: state <= S_IDLE;
        endcase
      end
    end
  end

  // write payload
  always_ff @(posedge i_sys_clk) begin
    if (i_clken) begin
      o_wr_addr <= wr_ptr;
      o_wr_data <= i_sample;
    end
  end

endmodule

//--- design/capture_ram.sv
`timescale 1ns/10ps

module capture_ram (
  input  logic                      i_sys_clk,
  input  logic                      i_wr_en,
  input  logic [la_pkg::ADDR_W-1:0] i_wr_addr,
  input  la_pkg::la_sample_u        i_wr_data,
  input  logic [la_pkg::ADDR_W-1:0] i_rd_addr,
  output la_pkg::la_sample_u        o_rd_data
);
  import la_pkg::*;

  la_sample_u mem [DEPTH];

  always_ff @(posedge i_sys_clk) begin
    if (i_wr_en) begin
      mem[i_wr_addr] <= i_wr_data;
    end
    o_rd_data <= mem[i_rd_addr];  // one cycle read latency
  end

endmodule

//--- design/la_readout.sv
`timescale 1ns/10ps

module la_readout (
  input  logic                      i_sys_clk,
  input  logic                      i_reset,
  input  logic                      i_finished,
  input  logic [la_pkg::ADDR_W-1:0] i_start_addr,
  input  logic                      i_trigger_en,
  input  logic                      i_left,
  input  logic                      i_right,
  input  logic                      i_credit,
  output logic [la_pkg::ADDR_W-1:0] o_rd_addr,
  input  la_pkg::la_sample_u        i_rd_data,
  output logic                      o_rd_valid,
  output la_pkg::rd_beat_t          o_rd_beat
);
  import la_pkg::*;

  logic [CREDIT_W-1:0] credits;
  logic [ADDR_W-1:0]   offset;     // view window shift
  logic [ADDR_W-1:0]   rd_idx;     // next entry to fetch
  logic [ADDR_W-1:0]   beat_idx;   // index of the read in flight
  logic [ADDR_W-1:0]   step_r;
  logic [ADDR_W-1:0]   step_l;
  logic                fin_q;
  logic                streaming;
  logic                busy;
  logic                issue;

  // the read in flight already owns one of the held credits
  assign issue     = streaming & (credits > CREDIT_W'(o_rd_valid));
  assign busy      = streaming | o_rd_valid;
  assign o_rd_addr = i_start_addr + offset + rd_idx;
  assign step_r    = i_right ? ADDR_W'(VIEW_STEP) : '0;
  assign step_l    = i_left ? ADDR_W'(VIEW_STEP) : '0;

  assign o_rd_beat.index  = beat_idx;
  assign o_rd_beat.sample = i_rd_data;

  always_ff @(posedge i_sys_clk) begin
    if (i_reset) begin
      credits    <= '0;
      offset     <= '0;
      rd_idx     <= '0;
      fin_q      <= 1'b0;
      streaming  <= 1'b0;
      o_rd_valid <= 1'b0;
    end else begin
      fin_q      <= i_finished;
      o_rd_valid <= issue;  // data back from ram next cycle
      credits    <= credits + CREDIT_W'(i_credit) - CREDIT_W'(o_rd_valid);

      if (i_trigger_en) begin
        offset    <= '0;
        streaming <= 1'b0;
      end else if (i_finished && !fin_q) begin
        streaming <= 1'b1;
        rd_idx    <= '0;
      end else begin
        if (issue) begin
          rd_idx <= rd_idx + 1'b1;
          if (rd_idx == ADDR_W'(DEPTH - 1)) begin
            streaming <= 1'b0;  // last fetch issued
          end
        end
        if (!busy) begin
          offset <= offset + step_r - step_l;  // wraps mod DEPTH
        end
      end
    end
  end

  always_ff @(posedge i_sys_clk) begin
    if (issue) begin
      beat_idx <= rd_idx;
    end
  end

endmodule

//--- design/top_analyser.sv
`timescale 1ns/10ps

module top_analyser (
  input  logic                      i_sys_clk,
  input  logic                      i_reset,
  input  logic                      i_key0,
  input  logic                      i_key1,
  input  logic [2:0]                i_spi_data,
  input  logic [7:0]                i_data_in,
  input  logic                      i_trigger_en,
  input  logic [la_pkg::ADDR_W-1:0] i_pre_num,
  input  logic [2:0]                i_cpu_chn_sel,
  input  logic [2:0]                i_cpu_mode_sel,
  input  logic [3:0]                i_freq_sel,
  input  logic                      i_spi_en,
  input  logic                      i_credit,
  output logic                      o_finished,
  output logic                      o_rd_valid,
  output la_pkg::rd_beat_t          o_rd_beat
);
  import la_pkg::*;

  la_sample_u        sample;
  trig_cfg_t         cfg;
  logic              clken;
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  la_sample_u        wr_data;
  logic [ADDR_W-1:0] rd_addr;
  la_sample_u        rd_data;
  logic [ADDR_W-1:0] start_addr;
  logic              left_shift;
  logic              right_shift;

  // source and trigger select
  always_comb begin
    sample      = '0;
    cfg.pre_num = i_pre_num;
    if (i_spi_en) begin
      sample.spi.lanes = i_spi_data;
      cfg.chn          = 3'd5;       // top lane
      cfg.mode         = MODE_FALL;
    end else begin
      sample.raw = i_data_in;
      cfg.chn    = i_cpu_chn_sel;
      cfg.mode   = i_cpu_mode_sel;
    end
  end

  freq_div u_freq_div (
    .i_sys_clk  (i_sys_clk),
    .i_reset    (i_reset),
    .i_freq_sel (i_freq_sel),
    .o_clken    (clken)
  );

  key_filter u0_key_filter (
    .i_sys_clk    (i_sys_clk),
    .i_reset      (i_reset),
    .i_key        (i_key0),
    .o_press_flag (left_shift)
  );

  key_filter u1_key_filter (
    .i_sys_clk    (i_sys_clk),
    .i_reset      (i_reset),
    .i_key        (i_key1),
    .o_press_flag (right_shift)
  );

  sample_ctrl u_sample_ctrl (
    .i_sys_clk    (i_sys_clk),
    .i_reset      (i_reset),
    .i_clken      (clken),
    .i_trigger_en (i_trigger_en),
    .i_cfg        (cfg),
    .i_sample     (sample),
    .o_wr_en      (wr_en),
    .o_wr_addr    (wr_addr),
    .o_wr_data    (wr_data),
    .o_start_addr (start_addr),
    .o_finished   (o_finished)
  );

  capture_ram u_capture_ram (
    .i_sys_clk (i_sys_clk),
    .i_wr_en   (wr_en),
    .i_wr_addr (wr_addr),
    .i_wr_data (wr_data),
    .i_rd_addr (rd_addr),
    .o_rd_data (rd_data)
  );

  la_readout u_la_readout (
    .i_sys_clk    (i_sys_clk),
    .i_reset      (i_reset),
    .i_finished   (o_finished),
    .i_start_addr (start_addr),
    .i_trigger_en (i_trigger_en),
    .i_left       (left_shift),
    .i_right      (right_shift),
    .i_credit     (i_credit),
    .o_rd_addr    (rd_addr),
    .i_rd_data    (rd_data),
    .o_rd_valid   (o_rd_valid),
    .o_rd_beat    (o_rd_beat)
  );

endmodule

//--- test/la_properties.sv
`timescale 1ns/10ps

module la_properties (
  input logic                        i_sys_clk,
  input logic                        i_reset,
  input logic                        i_wr_en,
  input logic                        i_finished,
  input logic [la_pkg::CREDIT_W-1:0] i_credits,
  input logic                        i_rd_valid
);
  import la_pkg::*;

  // host never hands out more than the limit
  credit_limit: assert property (@(posedge i_sys_clk) disable iff (i_reset)
    i_credits <= CREDIT_W'(CREDIT_MAX))
    else $error("credit count %0d above limit", i_credits);

  no_write_when_done: assert property (@(posedge i_sys_clk) disable iff (i_reset)
    i_finished |-> !i_wr_en)
    else $error("buffer written after capture finished");

  // a beat in flight still owns its credit
  valid_needs_credit: assert property (@(posedge i_sys_clk) disable iff (i_reset)
    i_rd_valid |-> (i_credits != '0))
    else $error("beat sent with no credit held");

endmodule

bind sample_ctrl la_properties u_ctrl_props (
  .i_sys_clk  (i_sys_clk),
  .i_reset    (i_reset),
  .i_wr_en    (o_wr_en),
  .i_finished (o_finished),
  .i_credits  ('0),
  .i_rd_valid (1'b0)
);

bind la_readout la_properties u_readout_props (
  .i_sys_clk  (i_sys_clk),
  .i_reset    (i_reset),
  .i_wr_en    (1'b0),
  .i_finished (i_finished),
  .i_credits  (credits),
  .i_rd_valid (o_rd_valid)
);

//--- test/tb_top_analyser.sv
`timescale 1ns/10ps

module tb_top_analyser;
  import la_pkg::*;

  localparam int NUM_TESTS   = 10;
  localparam int MAX_PERIOD  = 4;                        // freq_sel stays at 2 or below
  localparam int WAIT_CYCLES = DEPTH * MAX_PERIOD * 4;
  localparam int WATCHDOG_NS = NUM_TESTS * WAIT_CYCLES * 40 + 20000;

  logic              clk;
  logic              reset;
  logic              key0;
  logic              key1;
  logic [2:0]        spi_data;
  logic [7:0]        data_in;
  logic              trigger_en;
  logic [ADDR_W-1:0] pre_num;
  logic [2:0]        chn_sel;
  logic [2:0]        mode_sel;
  logic [3:0]        freq_sel;
  logic              spi_en;
  logic              credit;
  logic              finished;
  logic              rd_valid;
  rd_beat_t          rd_beat;

  la_sample_u smp[$];   // sampled words with [0] the one before the arm
  rd_beat_t   got[$];
  logic [2:0] cfg_chn;
  logic [2:0] cfg_mode;
  int         cfg_pre;
  int         view_off;
  int         mcnt;     // mirror of the divider counter
  int         msel;
  int         held;     // credits held by the dut
  int         gap_left;
  bit         bursty;
  int         errors;
  int         checks;
  int         tests_run;
  int         failed_tests;

  top_analyser i_dut (
    .i_sys_clk      (clk),
    .i_reset        (reset),
    .i_key0         (key0),
    .i_key1         (key1),
    .i_spi_data     (spi_data),
    .i_data_in      (data_in),
    .i_trigger_en   (trigger_en),
    .i_pre_num      (pre_num),
    .i_cpu_chn_sel  (chn_sel),
    .i_cpu_mode_sel (mode_sel),
    .i_freq_sel     (freq_sel),
    .i_spi_en       (spi_en),
    .i_credit       (credit),
    .o_finished     (finished),
    .o_rd_valid     (rd_valid),
    .o_rd_beat      (rd_beat)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all tests completed");
    $display("SIMULATION FAILED");
    $finish;
  end

  function automatic int sample_period(int sel);
    return 1 << sel;
  endfunction

  function automatic bit trigger_fires(logic [2:0] mode, logic [2:0] chn,
                                       la_sample_u cur, la_sample_u old);
    bit c;
    bit o;
    c = cur.raw[chn];
    o = old.raw[chn];
    case (mode)
      MODE_HIGH: return c;
      MODE_LOW:  return !c;
      MODE_RISE: return c && !o;
      MODE_FALL: return !c && o;
      MODE_ANY:  return c != o;
      default:   return 1'b1;
    endcase
  endfunction

  task automatic check_beat(input rd_beat_t got_beat, input rd_beat_t exp_beat);
    checks++;
    if (got_beat !== exp_beat) begin
      errors++;
      $display("MISMATCH at %0t: beat %0d sample %h, expected beat %0d sample %h", $time,
               got_beat.index, got_beat.sample.raw, exp_beat.index, exp_beat.sample.raw);
    end
  endtask

  task automatic check_finished(input bit got_fin, input bit exp_fin);
    checks++;
    if (got_fin !== exp_fin) begin
      errors++;
      $display("MISMATCH at %0t: o_finished %0b, expected %0b", $time, got_fin, exp_fin);
    end
  endtask

  // one clock with the inputs as set now and the model kept in step
  task automatic run_cycle();
    la_sample_u cur;
    la_sample_u last;
    bit         v;
    v = rd_valid;
    if (v) begin
      got.push_back(rd_beat);
      if (held == 0) begin
        errors++;
        $display("beat %0d arrived at %0t with no credit held", rd_beat.index, $time);
      end
    end
    data_in  = 8'($urandom);
    spi_data = 3'($urandom);
    if (gap_left > 0) begin
      gap_left = gap_left - 1;
      credit   = 1'b0;
    end else begin
      credit = !reset && (held < CREDIT_MAX);
      if (bursty && $urandom_range(7, 0) == 0) begin
        gap_left = $urandom_range(12, 1);
      end
    end
    cur.raw = spi_en ? {2'b00, spi_data, 3'b000} : data_in;  // lanes sit in bits 5..3
    if (reset) begin
      mcnt = 0;
      msel = int'(freq_sel);
      smp.delete();
      smp.push_back('0);
      held = 0;
    end else begin
      if (mcnt == sample_period(msel) - 1) begin
        smp.push_back(cur);
        mcnt = 0;
        msel = int'(freq_sel);  // new rate from the wrap on
      end else begin
        mcnt++;
      end
      if (trigger_en) begin
        last = smp[$];
        smp.delete();
        smp.push_back(last);
        cfg_chn  = spi_en ? 3'd5 : chn_sel;
        cfg_mode = spi_en ? MODE_FALL : mode_sel;
        cfg_pre  = int'(pre_num);
        view_off = 0;
        got.delete();
      end
    end
    @(negedge clk);
    held = held + int'(credit) - int'(v);
  endtask

  task automatic press_key(input bit right, input int low_cycles);
    if (right) begin
      key1 = 1'b0;
    end else begin
      key0 = 1'b0;
    end
    repeat (low_cycles) run_cycle();
    key0 = 1'b1;
    key1 = 1'b1;
    repeat (6) run_cycle();
    if (low_cycles >= DEBOUNCE_CYCLES) begin
      view_off = (view_off + (right ? VIEW_STEP : DEPTH - VIEW_STEP)) % DEPTH;
    end
  endtask

  task automatic run_capture(input string name, input bit use_spi, input logic [3:0] sel,
                             input logic [2:0] mode, input bit with_keys);
    int       err0;
    int       n;
    int       j;
    int       base;
    rd_beat_t exp;
    err0       = errors;
    spi_en     = use_spi;
    freq_sel   = sel;
    mode_sel   = mode;
    chn_sel    = 3'($urandom);
    pre_num    = ADDR_W'($urandom);
    trigger_en = 1'b1;
    run_cycle();
    trigger_en = 1'b0;
    check_finished(finished, 1'b0);
    if (with_keys) begin
      press_key(1'b1, 24);
      press_key(1'b1, 24);
      press_key(1'b0, 24);
      press_key(1'b0, 8);  // glitch too short to count
    end
    n = 0;
    while (!finished && n < WAIT_CYCLES) begin
      run_cycle();
      n++;
    end
    n = 0;
    while (got.size() < DEPTH && n < WAIT_CYCLES) begin
      run_cycle();
      n++;
    end
    repeat (8) run_cycle();  // catch surplus beats
    check_finished(finished, 1'b1);
    if (got.size() != DEPTH) begin
      errors++;
      $display("test %s received %0d beats, not %0d", name, got.size(), DEPTH);
    end
    j = cfg_pre;
    while (j + 1 < smp.size() && !trigger_fires(cfg_mode, cfg_chn, smp[j+1], smp[j])) begin
      j++;
    end
    if (j + 1 >= smp.size()) begin
      errors++;
      $display("test %s: model found no trigger in the sampled data", name);
    end
    base = 1 + j - cfg_pre;  // stream opens pre_num samples before the trigger
    for (int k = 0; k < got.size() && k < DEPTH; k++) begin
      exp.index  = ADDR_W'(k);
      exp.sample = smp[base + (view_off + k) % DEPTH];
      check_beat(got[k], exp);
    end
    tests_run++;
    if (errors != err0) begin
      failed_tests++;
    end
    $display("test %0d %s: %s", tests_run, name, (errors == err0) ? "ok" : "wrong");
  endtask

  initial begin
    void'($urandom(32'h1f51a797));
    reset      = 1'b1;
    key0       = 1'b1;
    key1       = 1'b1;
    spi_data   = '0;
    data_in    = '0;
    trigger_en = 1'b0;
    pre_num    = '0;
    chn_sel    = '0;
    mode_sel   = '0;
    freq_sel   = '0;
    spi_en     = 1'b0;
    credit     = 1'b0;
    @(negedge clk);
    repeat (8) run_cycle();
    reset = 1'b0;
    check_finished(finished, 1'b0);
    run_capture("cpu rising edge", 1'b0, 4'd0, MODE_RISE, 1'b0);
    run_capture("mode high", 1'b0, 4'd0, MODE_HIGH, 1'b0);
    run_capture("mode low", 1'b0, 4'd1, MODE_LOW, 1'b0);
    run_capture("mode falling", 1'b0, 4'd2, MODE_FALL, 1'b0);
    run_capture("mode any edge", 1'b0, 4'd0, MODE_ANY, 1'b0);
    run_capture("mode immediate", 1'b0, 4'd1, 3'(5 + $urandom_range(2, 0)), 1'b0);
    run_capture("spi lanes", 1'b1, 4'd2, 3'($urandom), 1'b0);
    bursty = 1'b1;
    run_capture("credit back-pressure", 1'b0, 4'd0, MODE_RISE, 1'b0);
    bursty = 1'b0;
    run_capture("view keys", 1'b0, 4'd1, MODE_RISE, 1'b1);
    run_capture("re-arm", 1'b0, 4'd2, MODE_RISE, 1'b0);
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
design/la_pkg.sv
design/freq_div.sv
design/key_filter.sv
design/sample_ctrl.sv
design/capture_ram.sv
design/la_readout.sv
design/top_analyser.sv
test/la_properties.sv
test/tb_top_analyser.sv

//--- Makefile
TOP = tb_top_analyser

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
